// File: Bender.yml
package:
  name: peripheral_subsystem

sources:
  - files:
      - source/periph_pkg.sv
      - source/obi_to_reg.sv
      - source/reg_demux.sv
      - source/gpio.sv
      - source/intr_ctrl.sv
      - source/peripheral_subsystem.sv
  - target: simulation
    files:
      - tb/tb_peripheral_subsystem.sv

// File: build.f
source/periph_pkg.sv
source/obi_to_reg.sv
source/reg_demux.sv
source/gpio.sv
source/intr_ctrl.sv
source/peripheral_subsystem.sv
tb/tb_peripheral_subsystem.sv

// File: source/gpio.sv
/*
  32-pin GPIO with 2-flop input synchronizer and rising-edge interrupts.
  Interrupt state is write-one-to-clear; a new edge wins over a clear.
*/
`timescale 1ns/1ps

module gpio
  import periph_pkg::*;
(
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  logic              valid_i,
  input  logic              write_i,
  input  logic [OFF_W-1:0]  addr_i,
  input  logic [DATA_W-1:0] wdata_i,
  output logic [DATA_W-1:0] rdata_o,
  input  logic [DATA_W-1:0] gpio_i,
  output logic [DATA_W-1:0] gpio_o,
  output logic [DATA_W-1:0] gpio_en_o,
  output logic [DATA_W-1:0] intr_o
);

  logic [DATA_W-1:0] sync_q1;
  logic [DATA_W-1:0] sync_q2;
  logic [DATA_W-1:0] prev_q;
  logic [DATA_W-1:0] data_out_q;
  logic [DATA_W-1:0] dir_q;
  logic [DATA_W-1:0] intr_en_q;
  logic [DATA_W-1:0] intr_state_q;
  logic [DATA_W-1:0] rise;
  logic [DATA_W-1:0] clr;
  logic              wr;

  assign wr = valid_i & write_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sync_q1 <= '0;
      sync_q2 <= '0;
      prev_q  <= '0;
    end else begin
      sync_q1 <= gpio_i;
      sync_q2 <= sync_q1;
      prev_q  <= sync_q2;
    end
  end

  assign rise = sync_q2 & ~prev_q & intr_en_q;
  assign clr = (wr && addr_i == GPIO_INTR_STATE) ? wdata_i : '0;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      data_out_q   <= '0;
      dir_q        <= '0;
      intr_en_q    <= '0;
      intr_state_q <= '0;
    end else begin
      if (wr && addr_i == GPIO_DATA_OUT) data_out_q <= wdata_i;
      if (wr && addr_i == GPIO_DIR) dir_q <= wdata_i;
      if (wr && addr_i == GPIO_INTR_EN) intr_en_q <= wdata_i;
      intr_state_q <= (intr_state_q & ~clr) | rise;
    end
  end

  always_comb begin
    case (addr_i)
      GPIO_DATA_IN:    rdata_o = sync_q2;
      GPIO_DATA_OUT:   rdata_o = data_out_q;
      GPIO_DIR:        rdata_o = dir_q;
      GPIO_INTR_EN:    rdata_o = intr_en_q;
      GPIO_INTR_STATE: rdata_o = intr_state_q;
      default:         rdata_o = '0;
    endcase
  end

  assign gpio_o = data_out_q;
  assign gpio_en_o = dir_q;
  // Disabling a pin masks its pending state
  assign intr_o = intr_state_q & intr_en_q;

endmodule : gpio

// File: source/intr_ctrl.sv
/*
  Level-sensitive interrupt gateway, no priorities: lowest eligible ID wins.
  Reading CLAIM claims that ID; writing the ID to CLAIM completes it.
*/
`timescale 1ns/1ps

module intr_ctrl
  import periph_pkg::*;
(
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  logic               valid_i,
  input  logic               write_i,
  input  logic [OFF_W-1:0]   addr_i,
  input  logic [DATA_W-1:0]  wdata_i,
  output logic [DATA_W-1:0]  rdata_o,
  input  logic [NUM_SRC-1:0] src_i,
  output logic               irq_o,
  output logic               msip_o
);

  logic [NUM_SRC-1:0] src;
  logic [NUM_SRC-1:0] enable_q;
  logic [NUM_SRC-1:0] claimed_q;
  logic [NUM_SRC-1:0] eligible;
  logic [SRC_W-1:0]   claim_id;
  logic [SRC_W-1:0]   cmpl_id;
  logic               msip_q;
  logic               irq_q;
  logic               wr;
  logic               claim_rd;
  logic               cmpl_wr;

  // ID 0 never fires
  assign src = {src_i[NUM_SRC-1:1], 1'b0};
  assign eligible = src & enable_q & ~claimed_q;

  always_comb begin
    claim_id = '0;
    for (int i = NUM_SRC - 1; i > 0; i--) begin
      if (eligible[i]) claim_id = SRC_W'(i);
    end
  end

  assign wr = valid_i & write_i;
  assign claim_rd = valid_i & ~write_i & (addr_i == INTR_CLAIM);
  assign cmpl_wr = wr & (addr_i == INTR_CLAIM);
  assign cmpl_id = wdata_i[SRC_W-1:0];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      enable_q  <= '0;
      claimed_q <= '0;
      msip_q    <= 1'b0;
      irq_q     <= 1'b0;
    end else begin
      irq_q <= |eligible;
      if (wr && addr_i == INTR_ENABLE_LO) begin
        enable_q[DATA_W-1:0] <= {wdata_i[DATA_W-1:1], 1'b0};
      end
      if (wr && addr_i == INTR_ENABLE_HI) begin
        enable_q[NUM_SRC-1:DATA_W] <= wdata_i[NUM_SRC-DATA_W-1:0];
      end
      if (wr && addr_i == INTR_MSIP) msip_q <= wdata_i[0];
      if (claim_rd && claim_id != '0) claimed_q[claim_id] <= 1'b1;
      // Out of range IDs on complete are dropped
      if (cmpl_wr && cmpl_id < SRC_W'(NUM_SRC)) claimed_q[cmpl_id] <= 1'b0;
    end
  end

  always_comb begin
    case (addr_i)
      INTR_PENDING_LO: rdata_o = src[DATA_W-1:0];
      INTR_PENDING_HI: rdata_o = {{(2*DATA_W-NUM_SRC){1'b0}}, src[NUM_SRC-1:DATA_W]};
      INTR_ENABLE_LO:  rdata_o = enable_q[DATA_W-1:0];
      INTR_ENABLE_HI:  rdata_o = {{(2*DATA_W-NUM_SRC){1'b0}}, enable_q[NUM_SRC-1:DATA_W]};
      INTR_CLAIM:      rdata_o = {{(DATA_W-SRC_W){1'b0}}, claim_id};
      INTR_MSIP:       rdata_o = {{(DATA_W-1){1'b0}}, msip_q};
      default:         rdata_o = '0;
    endcase
  end

  assign irq_o = irq_q;
  assign msip_o = msip_q;

endmodule : intr_ctrl

// File: source/obi_to_reg.sv
/*
  Core request/grant/rvalid port to register bus, one access in flight.
  No byte enables; every write is a full word. Write responses carry zero data.
*/
`timescale 1ns/1ps

module obi_to_reg
  import periph_pkg::*;
(
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  logic              req_i,
  input  logic [DATA_W-1:0] addr_i,
  input  logic              we_i,
  input  logic [DATA_W-1:0] wdata_i,
  output logic              gnt_o,
  output logic              rvalid_o,
  output logic [DATA_W-1:0] rdata_o,
  output logic              err_o,
  output logic              reg_valid_o,
  output logic              reg_write_o,
  output logic [DATA_W-1:0] reg_addr_o,
  output logic [DATA_W-1:0] reg_wdata_o,
  input  logic              reg_ready_i,
  input  logic [DATA_W-1:0] reg_rdata_i,
  input  logic              reg_error_i
);

  bridge_state_e state_q;
  logic          accept;
  logic          done;

  assign gnt_o = (state_q == BR_IDLE);
  assign accept = req_i & gnt_o;
  assign done = (state_q == BR_BUSY) & reg_ready_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= BR_IDLE;
    end else begin
      case (state_q)
        BR_IDLE: if (accept) state_q <= BR_BUSY;
        BR_BUSY: if (reg_ready_i) state_q <= BR_RESP;
        default: state_q <= BR_IDLE;
      endcase
    end
  end

  // Request held on the bus until the target is ready
  always_ff @(posedge clk_i) begin
    if (accept) begin
      reg_write_o <= we_i;
      reg_addr_o  <= addr_i;
      reg_wdata_o <= wdata_i;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rdata_o <= '0;
      err_o   <= 1'b0;
    end else if (done) begin
      rdata_o <= reg_write_o ? '0 : reg_rdata_i;
      err_o   <= reg_error_i;
    end
  end

  assign reg_valid_o = (state_q == BR_BUSY);
  assign rvalid_o = (state_q == BR_RESP);

endmodule : obi_to_reg

// File: source/periph_pkg.sv
/*
  Shared constants for the peripheral subsystem: address map, register offsets
  and interrupt IDs. Target select is addr[15:12]; addr[31:16] is ignored.
*/
package periph_pkg;

  localparam int DATA_W = 32;
  // Offset width inside one target window
  localparam int OFF_W = 12;

  // Interrupt sources, ID 0 is reserved and never fires
  localparam int NEXT_INT = 4;
  localparam int NUM_SRC = 38;
  localparam int SRC_W = 6;

  localparam int ID_GPIO_BASE = 1;
  localparam int ID_DMA = 33;
  localparam int ID_EXT_BASE = 34;

  // Target indices, equal to the value of addr[15:12]
  localparam int IDX_INTR = 0;
  localparam int IDX_GPIO = 1;
  localparam int IDX_EXT = 2;
  localparam int NUM_TARGETS = 3;

  // GPIO register offsets
  localparam logic [OFF_W-1:0] GPIO_DATA_IN = 12'h000;
  localparam logic [OFF_W-1:0] GPIO_DATA_OUT = 12'h004;
  localparam logic [OFF_W-1:0] GPIO_DIR = 12'h008;
  localparam logic [OFF_W-1:0] GPIO_INTR_EN = 12'h00C;
  localparam logic [OFF_W-1:0] GPIO_INTR_STATE = 12'h010;

  // Interrupt controller register offsets
  localparam logic [OFF_W-1:0] INTR_PENDING_LO = 12'h000;
  localparam logic [OFF_W-1:0] INTR_PENDING_HI = 12'h004;
  localparam logic [OFF_W-1:0] INTR_ENABLE_LO = 12'h008;
  localparam logic [OFF_W-1:0] INTR_ENABLE_HI = 12'h00C;
  localparam logic [OFF_W-1:0] INTR_CLAIM = 12'h010;
  localparam logic [OFF_W-1:0] INTR_MSIP = 12'h014;

  // Bridge FSM
  typedef enum logic [1:0] {
    BR_IDLE,
    BR_BUSY,
    BR_RESP
  } bridge_state_e;

endpackage : periph_pkg

// File: source/peripheral_subsystem.sv
/*
  Peripheral subsystem: bridge, decoder, GPIO and interrupt controller.
  ext_reg_* leaves with a 12-bit offset and may stall with ext_reg_ready_i.
*/
`timescale 1ns/1ps

module peripheral_subsystem
  import periph_pkg::*;
(
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  logic                req_i,
  input  logic [DATA_W-1:0]   addr_i,
  input  logic                we_i,
  input  logic [DATA_W-1:0]   wdata_i,
  output logic                gnt_o,
  output logic                rvalid_o,
  output logic [DATA_W-1:0]   rdata_o,
  output logic                err_o,
  input  logic [DATA_W-1:0]   gpio_i,
  output logic [DATA_W-1:0]   gpio_o,
  output logic [DATA_W-1:0]   gpio_en_o,
  input  logic                dma_intr_i,
  input  logic [NEXT_INT-1:0] intr_ext_i,
  output logic                irq_o,
  output logic                msip_o,
  output logic                ext_reg_valid_o,
  output logic                ext_reg_write_o,
  output logic [OFF_W-1:0]    ext_reg_addr_o,
  output logic [DATA_W-1:0]   ext_reg_wdata_o,
  input  logic                ext_reg_ready_i,
  input  logic [DATA_W-1:0]   ext_reg_rdata_i
);

  logic               reg_valid;
  logic               reg_write;
  logic [DATA_W-1:0]  reg_addr;
  logic [DATA_W-1:0]  reg_wdata;
  logic               reg_ready;
  logic [DATA_W-1:0]  reg_rdata;
  logic               reg_error;
  logic               intr_valid;
  logic               intr_write;
  logic               gpio_valid;
  logic               gpio_write;
  logic [OFF_W-1:0]   tgt_addr;
  logic [DATA_W-1:0]  tgt_wdata;
  logic [DATA_W-1:0]  intr_rdata;
  logic [DATA_W-1:0]  gpio_rdata;
  logic [DATA_W-1:0]  gpio_intr;
  logic [NUM_SRC-1:0] intr_vector;

  // Source layout: zero, GPIO pins, DMA, external
  assign intr_vector[0] = 1'b0;
  assign intr_vector[ID_GPIO_BASE +: DATA_W] = gpio_intr;
  assign intr_vector[ID_DMA] = dma_intr_i;
  assign intr_vector[ID_EXT_BASE +: NEXT_INT] = intr_ext_i;

  assign ext_reg_addr_o = tgt_addr;
  assign ext_reg_wdata_o = tgt_wdata;

  obi_to_reg u_bridge (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .req_i       (req_i),
    .addr_i      (addr_i),
    .we_i        (we_i),
    .wdata_i     (wdata_i),
    .gnt_o       (gnt_o),
    .rvalid_o    (rvalid_o),
    .rdata_o     (rdata_o),
    .err_o       (err_o),
    .reg_valid_o (reg_valid),
    .reg_write_o (reg_write),
    .reg_addr_o  (reg_addr),
    .reg_wdata_o (reg_wdata),
    .reg_ready_i (reg_ready),
    .reg_rdata_i (reg_rdata),
    .reg_error_i (reg_error)
  );

  reg_demux u_demux (
    .reg_valid_i  (reg_valid),
    .reg_write_i  (reg_write),
    .reg_addr_i   (reg_addr),
    .reg_wdata_i  (reg_wdata),
    .reg_ready_o  (reg_ready),
    .reg_rdata_o  (reg_rdata),
    .reg_error_o  (reg_error),
    .intr_valid_o (intr_valid),
    .intr_write_o (intr_write),
    .gpio_valid_o (gpio_valid),
    .gpio_write_o (gpio_write),
    .ext_valid_o  (ext_reg_valid_o),
    .ext_write_o  (ext_reg_write_o),
    .tgt_addr_o   (tgt_addr),
    .tgt_wdata_o  (tgt_wdata),
    .intr_rdata_i (intr_rdata),
    .gpio_rdata_i (gpio_rdata),
    .ext_ready_i  (ext_reg_ready_i),
    .ext_rdata_i  (ext_reg_rdata_i)
  );

  gpio u_gpio (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .valid_i   (gpio_valid),
    .write_i   (gpio_write),
    .addr_i    (tgt_addr),
    .wdata_i   (tgt_wdata),
    .rdata_o   (gpio_rdata),
    .gpio_i    (gpio_i),
    .gpio_o    (gpio_o),
    .gpio_en_o (gpio_en_o),
    .intr_o    (gpio_intr)
  );

  intr_ctrl u_intr (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .valid_i  (intr_valid),
    .write_i  (intr_write),
    .addr_i   (tgt_addr),
    .wdata_i  (tgt_wdata),
    .rdata_o  (intr_rdata),
    .src_i    (intr_vector),
    .irq_o    (irq_o),
    .msip_o   (msip_o)
  );

endmodule : peripheral_subsystem

// File: source/reg_demux.sv
/*
  Routes register accesses by addr[15:12]. Internal targets answer in the same
  cycle; only the external port can stall. Bad addresses give an error, no data.
*/
`timescale 1ns/1ps

module reg_demux
  import periph_pkg::*;
(
  input  logic              reg_valid_i,
  input  logic              reg_write_i,
  input  logic [DATA_W-1:0] reg_addr_i,
  input  logic [DATA_W-1:0] reg_wdata_i,
  output logic              reg_ready_o,
  output logic [DATA_W-1:0] reg_rdata_o,
  output logic              reg_error_o,
  output logic              intr_valid_o,
  output logic              intr_write_o,
  output logic              gpio_valid_o,
  output logic              gpio_write_o,
  output logic              ext_valid_o,
  output logic              ext_write_o,
  output logic [OFF_W-1:0]  tgt_addr_o,
  output logic [DATA_W-1:0] tgt_wdata_o,
  input  logic [DATA_W-1:0] intr_rdata_i,
  input  logic [DATA_W-1:0] gpio_rdata_i,
  input  logic              ext_ready_i,
  input  logic [DATA_W-1:0] ext_rdata_i
);

  logic [3:0]             sel;
  logic [OFF_W-1:0]       offset;
  logic [NUM_TARGETS-1:0] hit;
  logic                   dec_err;

  assign sel = reg_addr_i[15:12];
  assign offset = reg_addr_i[OFF_W-1:0];

  always_comb begin
    hit = '0;
    dec_err = 1'b0;
    case (sel)
      4'(IDX_INTR): begin
        if (offset > INTR_MSIP) dec_err = 1'b1;
        else hit[IDX_INTR] = 1'b1;
      end
      4'(IDX_GPIO): begin
        if (offset > GPIO_INTR_STATE) dec_err = 1'b1;
        else hit[IDX_GPIO] = 1'b1;
      end
      4'(IDX_EXT): hit[IDX_EXT] = 1'b1;
      default: dec_err = 1'b1;
    endcase
  end

  assign intr_valid_o = reg_valid_i & hit[IDX_INTR];
  assign gpio_valid_o = reg_valid_i & hit[IDX_GPIO];
  assign ext_valid_o = reg_valid_i & hit[IDX_EXT];

  assign intr_write_o = reg_write_i & hit[IDX_INTR];
  assign gpio_write_o = reg_write_i & hit[IDX_GPIO];
  assign ext_write_o = reg_write_i & hit[IDX_EXT];

  assign tgt_addr_o = offset;
  assign tgt_wdata_o = reg_wdata_i;

  // Only the external port may hold ready low
  assign reg_ready_o = hit[IDX_EXT] ? ext_ready_i : 1'b1;
  assign reg_error_o = dec_err;

  always_comb begin
    reg_rdata_o = '0;
    if (hit[IDX_INTR]) reg_rdata_o = intr_rdata_i;
    if (hit[IDX_GPIO]) reg_rdata_o = gpio_rdata_i;
    if (hit[IDX_EXT]) reg_rdata_o = ext_rdata_i;
  end

endmodule : reg_demux

// File: tb/tb_peripheral_subsystem.sv
/*
  Self-checking testbench; the first failed check ends the run.
  External register target is a 16-word model with 0 to 3 random wait cycles.
*/
`timescale 1ns/1ps

module tb_peripheral_subsystem
  import periph_pkg::*;
();

  localparam int CLK_PERIOD = 8;
  localparam int RESET_CYCLES = 10;
  localparam int SYNC_SETTLE = 4;
  // Upper bound on bus accesses issued by all tests together
  localparam int NUM_ACCESSES = 64;
  localparam int WATCHDOG_CYCLES = RESET_CYCLES + NUM_ACCESSES * 200;

  localparam logic [DATA_W-1:0] INTR_BASE = 32'(IDX_INTR) << 12;
  localparam logic [DATA_W-1:0] GPIO_BASE = 32'(IDX_GPIO) << 12;
  localparam logic [DATA_W-1:0] EXT_BASE = 32'(IDX_EXT) << 12;
  localparam int PIN = 3;
  localparam int OFF_PIN = 5;
  localparam logic [NEXT_INT-1:0] EXT_PATTERN = NEXT_INT'(5);

  logic                clk_i;
  logic                arst_n_i;
  logic                req_i;
  logic [DATA_W-1:0]   addr_i;
  logic                we_i;
  logic [DATA_W-1:0]   wdata_i;
  logic                gnt_o;
  logic                rvalid_o;
  logic [DATA_W-1:0]   rdata_o;
  logic                err_o;
  logic [DATA_W-1:0]   gpio_i;
  logic [DATA_W-1:0]   gpio_o;
  logic [DATA_W-1:0]   gpio_en_o;
  logic                dma_intr_i;
  logic [NEXT_INT-1:0] intr_ext_i;
  logic                irq_o;
  logic                msip_o;
  logic                ext_reg_valid_o;
  logic                ext_reg_write_o;
  logic [OFF_W-1:0]    ext_reg_addr_o;
  logic [DATA_W-1:0]   ext_reg_wdata_o;
  logic                ext_reg_ready_i = 1'b0;
  logic [DATA_W-1:0]   ext_reg_rdata_i = '0;

  logic [DATA_W-1:0]   ext_mem [16];
  logic                ext_busy = 1'b0;
  int                  ext_wait = 0;
  integer              seed = 32'h4b6f;

  peripheral_subsystem u_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // Reset contents of the external model, different for every word
  function automatic logic [DATA_W-1:0] ext_fill(input int idx);
    return 32'hC0DE_0000 ^ (32'(idx) * 32'h0001_0203) ^ 32'(idx);
  endfunction

  // External register target, ready after 0 to 3 extra cycles
  always @(posedge clk_i) begin
    if (!arst_n_i) begin
      ext_reg_ready_i <= 1'b0;
      ext_busy = 1'b0;
      for (int i = 0; i < 16; i++) ext_mem[i] = ext_fill(i);
    end else begin
      ext_reg_ready_i <= 1'b0;
      if (ext_reg_valid_o && !ext_reg_ready_i) begin
        if (!ext_busy) begin
          ext_busy = 1'b1;
          ext_wait = $unsigned($random(seed)) % 4;
        end
        if (ext_wait == 0) begin
          if (ext_reg_write_o) ext_mem[ext_reg_addr_o[5:2]] = ext_reg_wdata_o;
          ext_reg_rdata_i <= ext_mem[ext_reg_addr_o[5:2]];
          ext_reg_ready_i <= 1'b1;
          ext_busy = 1'b0;
        end else begin
          ext_wait = ext_wait - 1;
        end
      end
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("Timeout after %0d cycles, a bus access or interrupt wait hung", WATCHDOG_CYCLES);
    $display("=== FAIL ===");
    $fatal(1);
  end

  task automatic check_eq(input string what, input logic [DATA_W-1:0] got,
                          input logic [DATA_W-1:0] exp);
    assert (got === exp)
    else begin
      $display("ERR %0t: %s, got 0x%08h, expected 0x%08h", $time, what, got, exp);
      $display("=== FAIL ===");
      $fatal(1);
    end
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk_i);
  endtask

  task automatic wait_for_irq(input logic level, input int max_cycles);
    int n;
    n = 0;
    while (irq_o !== level && n < max_cycles) begin
      @(posedge clk_i);
      n++;
    end
    assert (irq_o === level)
    else begin
      $display("irq_o did not go to %0b within %0d cycles at %0t", level, max_cycles, $time);
      $display("=== FAIL ===");
      $fatal(1);
    end
  endtask

  // Called right after a rising edge; returns at the edge that sees rvalid_o
  task automatic run_access(input logic we, input logic [DATA_W-1:0] addr,
                            input logic [DATA_W-1:0] wdata,
                            output logic [DATA_W-1:0] rdata, output logic err);
    req_i   <= 1'b1;
    we_i    <= we;
    addr_i  <= addr;
    wdata_i <= wdata;
    @(posedge clk_i);
    while (!gnt_o) @(posedge clk_i);
    req_i <= 1'b0;
    @(posedge clk_i);
    while (!rvalid_o) @(posedge clk_i);
    rdata = rdata_o;
    err = err_o;
  endtask

  task automatic bus_write(input logic [DATA_W-1:0] addr, input logic [DATA_W-1:0] data);
    logic [DATA_W-1:0] rd;
    logic              err;
    run_access(1'b1, addr, data, rd, err);
    check_eq($sformatf("err_o on write to 0x%08h", addr), err, 1'b0);
    check_eq($sformatf("write response data at 0x%08h", addr), rd, '0);
  endtask

  task automatic bus_read(input logic [DATA_W-1:0] addr, output logic [DATA_W-1:0] data);
    logic err;
    run_access(1'b0, addr, '0, data, err);
    check_eq($sformatf("err_o on read of 0x%08h", addr), err, 1'b0);
  endtask

  task automatic expect_error(input logic we, input logic [DATA_W-1:0] addr);
    logic [DATA_W-1:0] rd;
    logic              err;
    run_access(we, addr, 32'hDEAD_BEEF, rd, err);
    check_eq($sformatf("err_o for bad address 0x%08h", addr), err, 1'b1);
    check_eq($sformatf("read data for bad address 0x%08h", addr), rd, '0);
  endtask

  initial begin
    logic [DATA_W-1:0] rd;
    logic [DATA_W-1:0] exp;
    logic [DATA_W-1:0] ext_addr;
    int                ids[$];
    arst_n_i   = 1'b0;
    req_i      = 1'b0;
    addr_i     = '0;
    we_i       = 1'b0;
    wdata_i    = '0;
    gpio_i     = '0;
    dma_intr_i = 1'b0;
    intr_ext_i = '0;
    wait_cycles(RESET_CYCLES);
    arst_n_i <= 1'b1;
    @(posedge clk_i);

    // Reset state
    check_eq("gnt_o after reset", gnt_o, 1'b1);
    check_eq("rvalid_o after reset", rvalid_o, 1'b0);
    check_eq("irq_o after reset", irq_o, 1'b0);
    check_eq("msip_o after reset", msip_o, 1'b0);
    check_eq("gpio_o after reset", gpio_o, '0);
    check_eq("gpio_en_o after reset", gpio_en_o, '0);
    check_eq("ext_reg_valid_o after reset", ext_reg_valid_o, 1'b0);
    check_eq("bridge state after reset", 32'(u_dut.u_bridge.state_q), 32'(BR_IDLE));

    // GPIO outputs
    bus_write(GPIO_BASE + 32'(GPIO_DATA_OUT), 32'hA5A5_0F0F);
    bus_write(GPIO_BASE + 32'(GPIO_DIR), 32'hFF00_FF00);
    check_eq("gpio_o", gpio_o, 32'hA5A5_0F0F);
    check_eq("gpio_en_o", gpio_en_o, 32'hFF00_FF00);
    bus_read(GPIO_BASE + 32'(GPIO_DATA_OUT), rd);
    check_eq("GPIO_DATA_OUT readback", rd, 32'hA5A5_0F0F);
    bus_read(GPIO_BASE + 32'(GPIO_DIR), rd);
    check_eq("GPIO_DIR readback", rd, 32'hFF00_FF00);

    // GPIO inputs and edge detection
    gpio_i <= 32'h1234_5678;
    wait_cycles(SYNC_SETTLE);
    bus_read(GPIO_BASE + 32'(GPIO_DATA_IN), rd);
    check_eq("GPIO_DATA_IN", rd, 32'h1234_5678);
    gpio_i <= '0;
    wait_cycles(SYNC_SETTLE);
    bus_write(GPIO_BASE + 32'(GPIO_INTR_EN), 32'd1 << PIN);
    gpio_i <= (32'd1 << PIN) | (32'd1 << OFF_PIN);
    wait_cycles(SYNC_SETTLE);
    bus_read(GPIO_BASE + 32'(GPIO_INTR_STATE), rd);
    check_eq("GPIO_INTR_STATE after rising edges", rd, 32'd1 << PIN);
    bus_write(GPIO_BASE + 32'(GPIO_INTR_STATE), 32'd1 << PIN);
    bus_read(GPIO_BASE + 32'(GPIO_INTR_STATE), rd);
    check_eq("GPIO_INTR_STATE after clear", rd, '0);

    // Claim and complete of one GPIO interrupt
    gpio_i <= '0;
    wait_cycles(SYNC_SETTLE);
    bus_write(INTR_BASE + 32'(INTR_ENABLE_LO), 32'd1 << (PIN + ID_GPIO_BASE));
    check_eq("irq_o before GPIO edge", irq_o, 1'b0);
    gpio_i <= 32'd1 << PIN;
    wait_for_irq(1'b1, 10);
    bus_read(INTR_BASE + 32'(INTR_CLAIM), rd);
    check_eq("claimed GPIO ID", rd, 32'(PIN + ID_GPIO_BASE));
    wait_for_irq(1'b0, 4);
    bus_read(INTR_BASE + 32'(INTR_PENDING_LO), rd);
    check_eq("INTR_PENDING_LO while claimed", rd, 32'd1 << (PIN + ID_GPIO_BASE));
    bus_write(INTR_BASE + 32'(INTR_CLAIM), 32'(PIN + ID_GPIO_BASE));
    wait_for_irq(1'b1, 4);
    bus_write(INTR_BASE + 32'(INTR_ENABLE_LO), '0);
    bus_write(GPIO_BASE + 32'(GPIO_INTR_STATE), 32'd1 << PIN);
    wait_for_irq(1'b0, 4);
    gpio_i <= '0;

    // Lowest eligible ID wins
    dma_intr_i <= 1'b1;
    intr_ext_i <= EXT_PATTERN;
    exp = (32'd1 << (ID_DMA - DATA_W)) |
          (((32'd1 << NEXT_INT) - 1) << (ID_EXT_BASE - DATA_W));
    bus_write(INTR_BASE + 32'(INTR_ENABLE_HI), exp);
    bus_read(INTR_BASE + 32'(INTR_PENDING_HI), rd);
    exp = (32'd1 << (ID_DMA - DATA_W)) | (32'(EXT_PATTERN) << (ID_EXT_BASE - DATA_W));
    check_eq("INTR_PENDING_HI", rd, exp);
    wait_for_irq(1'b1, 4);
    ids.push_back(ID_DMA);
    for (int i = 0; i < NEXT_INT; i++) begin
      if (EXT_PATTERN[i]) ids.push_back(ID_EXT_BASE + i);
    end
    foreach (ids[k]) begin
      bus_read(INTR_BASE + 32'(INTR_CLAIM), rd);
      check_eq("claim order", rd, 32'(ids[k]));
    end
    bus_read(INTR_BASE + 32'(INTR_CLAIM), rd);
    check_eq("claim with nothing eligible", rd, '0);
    foreach (ids[k]) bus_write(INTR_BASE + 32'(INTR_CLAIM), 32'(ids[k]));
    dma_intr_i <= 1'b0;
    intr_ext_i <= '0;
    bus_write(INTR_BASE + 32'(INTR_ENABLE_HI), '0);
    wait_for_irq(1'b0, 4);

    // External port under random stalls; upper address bits are don't care
    for (int k = 0; k < 6; k++) begin
      ext_addr = 32'h7F00_0000 | EXT_BASE | 32'(k * 3 * 4);
      exp = 32'hD00D_0000 + 32'(k) * 32'h0001_0101;
      bus_write(ext_addr, exp);
      check_eq("external model word after write", ext_mem[k * 3], exp);
      bus_read(ext_addr, rd);
      check_eq("external readback", rd, exp);
    end
    bus_read(EXT_BASE + 32'(14 * 4), rd);
    check_eq("external unwritten word", rd, ext_fill(14));

    // Unmapped targets and offsets past the last register
    expect_error(1'b0, 32'h0000_3000);
    expect_error(1'b1, 32'h0000_F004);
    expect_error(1'b0, INTR_BASE + 32'(INTR_MSIP) + 32'd4);
    expect_error(1'b0, GPIO_BASE + 32'(GPIO_INTR_STATE) + 32'd4);
    expect_error(1'b1, GPIO_BASE + 32'h0000_0100);

    // Software interrupt
    bus_write(INTR_BASE + 32'(INTR_MSIP), 32'd1);
    check_eq("msip_o after set", msip_o, 1'b1);
    bus_read(INTR_BASE + 32'(INTR_MSIP), rd);
    check_eq("INTR_MSIP readback", rd, 32'd1);
    bus_write(INTR_BASE + 32'(INTR_MSIP), 32'hFFFF_FFFE);
    check_eq("msip_o after clear", msip_o, 1'b0);

    $display("=== PASS ===");
    $finish;
  end

endmodule : tb_peripheral_subsystem
